//--- dec_pkg.sv
// Decode unit shared definitions
// widths, counts and packed bundles for the register file, load tags and trace
`default_nettype none

package dec_pkg;

   // **************************************************************************
   // widths and counts
   // **************************************************************************
   localparam int xlen         = 32;                   // data width
   localparam int num_gpr      = 32;                   // x0..x31
   localparam int gpr_addr_w   = 5;                    // log2(num_gpr)
   localparam int num_nbload   = 4;                    // outstanding nonblock loads
   localparam int nbload_tag_w = 2;                    // log2(num_nbload)
   localparam int num_ecause_w = 5;                    // mcause code width

   // **************************************************************************
   // bundles
   // **************************************************************************
   typedef struct packed {
      logic                  en;                       // read port enable
      logic [gpr_addr_w-1:0] addr;                     // source register
   } gpr_rd_t;

   typedef struct packed {
      logic                  en;                       // write enable
      logic [gpr_addr_w-1:0] addr;                     // dest register
      logic [xlen-1:0]       data;                     // write data
   } gpr_wr_t;

   typedef struct packed {
      logic            valid;                          // retiring normally
      logic            exc_valid;                      // retiring with exception
      logic [31:0]     instr;                          // full 32b encoding
      logic [31:1]     pc;                             // halfword aligned pc
   } wb_slot_t;

   // three trace ports: slot 0, slot 1, interrupt
   typedef struct packed {
      logic [3*xlen-1:0]       insn;                   // {0, i1, i0}
      logic [3*xlen-1:0]       address;                // {0, pc1,0, pc0,0}
      logic [2:0]              valid;
      logic [2:0]              exception;
      logic [num_ecause_w-1:0] ecause;                 // shared by all ports
      logic [2:0]              interrupt;
      logic [xlen-1:0]         tval;                   // shared by all ports
   } trace_pkt_t;

endpackage

`default_nettype wire

//--- dec_nbload_ctl.sv
// Non-blocking load tag table
// remembers the destination register of each outstanding load by tag and
// turns a clean data return into a write on the third register file port
`default_nettype none

module dec_nbload_ctl
   import dec_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,

   input  logic                    nbload_valid_dc3,   // load issued at dc3
   input  logic [nbload_tag_w-1:0] nbload_tag_dc3,     // its tag
   input  logic [gpr_addr_w-1:0]   nbload_rd_dc3,      // its dest register

   input  logic                    nbload_inv_dc5,     // load killed at dc5
   input  logic [nbload_tag_w-1:0] nbload_inv_tag_dc5,

   input  logic                    nbload_data_valid,  // data back from bus
   input  logic                    nbload_data_error,  // bus error on return
   input  logic [nbload_tag_w-1:0] nbload_data_tag,
   input  logic [xlen-1:0]         nbload_data,

   output gpr_wr_t                 nbload_wr           // to register file port 2
);

   logic [num_nbload-1:0] tag_valid;                   // entry allocated
   logic [gpr_addr_w-1:0] tag_rd [num_nbload];         // dest per entry
   logic [num_nbload-1:0] set_vec;                     // allocate this cycle
   logic [num_nbload-1:0] clr_vec;                     // free this cycle
   logic                  inv_same;                    // return tag killed now
   logic [gpr_addr_w-1:0] ret_rd;                      // dest of returning tag

   // one-hot decode of the three tag events
   always_comb begin
      for (int i = 0; i < num_nbload; i++) begin
         set_vec[i] = nbload_valid_dc3 && (nbload_tag_dc3 == nbload_tag_w'(i));
         clr_vec[i] = (nbload_inv_dc5 && (nbload_inv_tag_dc5 == nbload_tag_w'(i))) ||
                      (nbload_data_valid && (nbload_data_tag == nbload_tag_w'(i)));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tag_valid <= '0;                              // nothing outstanding
      end else begin
         tag_valid <= set_vec | (tag_valid & ~clr_vec); // set beats free
      end
   end

   // dest register is payload, only loaded on allocate
   always_ff @(posedge clk) begin
      for (int i = 0; i < num_nbload; i++) begin
         if (set_vec[i]) begin
            tag_rd[i] <= nbload_rd_dc3;
         end
      end
   end

   // **************************************************************************
   // data return
   // **************************************************************************
   assign inv_same = nbload_inv_dc5 && (nbload_inv_tag_dc5 == nbload_data_tag);
   assign ret_rd   = tag_rd[nbload_data_tag];

   assign nbload_wr.en   = nbload_data_valid &&
                           tag_valid[nbload_data_tag] &&  // was allocated
                           !inv_same &&                   // not killed this cycle
                           !nbload_data_error &&          // bus ok
                           (ret_rd != '0);                // x0 never written
   assign nbload_wr.addr = ret_rd;
   assign nbload_wr.data = nbload_data;                // straight from the bus

endmodule

`default_nettype wire

//--- dec_gpr_ctl.sv
// Architectural register file
// x1..x31 with three prioritized write ports and four enabled read ports
// where x0 and disabled ports read as zero
`default_nettype none

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic            clk,
   input  logic            reset,

   input  gpr_wr_t         i0_wr,                      // slot 0 writeback
   input  gpr_wr_t         i1_wr,                      // slot 1 writeback
   input  gpr_wr_t         nbload_wr,                  // nonblock load return

   input  gpr_rd_t         i0_rs1,
   input  gpr_rd_t         i0_rs2,
   input  gpr_rd_t         i1_rs1,
   input  gpr_rd_t         i1_rs2,

   output logic [xlen-1:0] i0_rs1_data,
   output logic [xlen-1:0] i0_rs2_data,
   output logic [xlen-1:0] i1_rs1_data,
   output logic [xlen-1:0] i1_rs2_data
);

   logic [xlen-1:0] gpr_q [1:num_gpr-1];               // x0 has no storage
   logic [xlen-1:0] rf    [num_gpr];                   // read view with rf[0] tied to zero
   logic [num_gpr-1:1] wen_i0;                         // per register selects
   logic [num_gpr-1:1] wen_i1;
   logic [num_gpr-1:1] wen_nb;

   // **************************************************************************
   // write decode
   // **************************************************************************
   always_comb begin
      for (int i = 1; i < num_gpr; i++) begin         // x0 writes drop out here
         wen_i0[i] = i0_wr.en     && (i0_wr.addr     == gpr_addr_w'(i));
         wen_i1[i] = i1_wr.en     && (i1_wr.addr     == gpr_addr_w'(i));
         wen_nb[i] = nbload_wr.en && (nbload_wr.addr == gpr_addr_w'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 1; i < num_gpr; i++) begin
         if (reset) begin
            gpr_q[i] <= '0;
         end else if (wen_i1[i]) begin                 // youngest slot wins
            gpr_q[i] <= i1_wr.data;
         end else if (wen_i0[i]) begin
            gpr_q[i] <= i0_wr.data;
         end else if (wen_nb[i]) begin                 // load return is last
            gpr_q[i] <= nbload_wr.data;
         end
      end
   end

   // **************************************************************************
   // read ports without bypass from same-cycle writes
   // **************************************************************************
   always_comb begin
      rf[0] = '0;                                      // hardwired zero
      for (int i = 1; i < num_gpr; i++) begin
         rf[i] = gpr_q[i];
      end
   end

   assign i0_rs1_data = i0_rs1.en ? rf[i0_rs1.addr] : '0;
   assign i0_rs2_data = i0_rs2.en ? rf[i0_rs2.addr] : '0;
   assign i1_rs1_data = i1_rs1.en ? rf[i1_rs1.addr] : '0;
   assign i1_rs2_data = i1_rs2.en ? rf[i1_rs2.addr] : '0;

endmodule

`default_nettype wire

//--- dec_trace_ctl.sv
// Retirement trace capture
// flops the writeback slots and trap info into wb1 and packs them into the
// three-port instruction trace packet
`default_nettype none

module dec_trace_ctl
   import dec_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,

   input  wb_slot_t                i0_wb,              // slot 0 at writeback
   input  wb_slot_t                i1_wb,              // slot 1 at writeback
   input  logic                    int_valid_wb,       // interrupt taken
   input  logic [num_ecause_w-1:0] exc_cause_wb,
   input  logic [xlen-1:0]         mtval_wb,

   output trace_pkt_t              trace_pkt           // wb1 trace packet
);

   wb_slot_t                i0_wb1;
   wb_slot_t                i1_wb1;
   logic                    int_valid_wb1;
   logic [num_ecause_w-1:0] exc_cause_wb1;
   logic [xlen-1:0]         mtval_wb1;

   // **************************************************************************
   // wb -> wb1
   // **************************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         i0_wb1.valid     <= 1'b0;
         i0_wb1.exc_valid <= 1'b0;
         i1_wb1.valid     <= 1'b0;
         i1_wb1.exc_valid <= 1'b0;
         int_valid_wb1    <= 1'b0;
      end else begin
         i0_wb1.valid     <= i0_wb.valid;
         i0_wb1.exc_valid <= i0_wb.exc_valid;
         i1_wb1.valid     <= i1_wb.valid;
         i1_wb1.exc_valid <= i1_wb.exc_valid;
         int_valid_wb1    <= int_valid_wb;
      end
   end

   always_ff @(posedge clk) begin                      // payload only
      i0_wb1.instr  <= i0_wb.instr;
      i0_wb1.pc     <= i0_wb.pc;
      i1_wb1.instr  <= i1_wb.instr;
      i1_wb1.pc     <= i1_wb.pc;
      exc_cause_wb1 <= exc_cause_wb;
      mtval_wb1     <= mtval_wb;
   end

   // **************************************************************************
   // packet, port 2 carries the interrupt
   // **************************************************************************
   assign trace_pkt.insn      = {32'b0, i1_wb1.instr, i0_wb1.instr};
   assign trace_pkt.address   = {32'b0, i1_wb1.pc, 1'b0, i0_wb1.pc, 1'b0}; // byte addrs
   assign trace_pkt.valid     = {int_valid_wb1,
                                 i1_wb1.valid | i1_wb1.exc_valid,
                                 i0_wb1.valid | i0_wb1.exc_valid};
   assign trace_pkt.exception = {int_valid_wb1, i1_wb1.exc_valid, i0_wb1.exc_valid};
   assign trace_pkt.interrupt = {int_valid_wb1, 2'b0};
   assign trace_pkt.ecause    = exc_cause_wb1;        // common to all ports
   assign trace_pkt.tval      = mtval_wb1;

endmodule

`default_nettype wire

//--- dec.sv
// Decode unit register file slice
// load tag tracking feeding the register file, plus retirement trace capture
`default_nettype none

module dec
   import dec_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,

   // nonblock load tracking
   input  logic                    nbload_valid_dc3,
   input  logic [nbload_tag_w-1:0] nbload_tag_dc3,
   input  logic [gpr_addr_w-1:0]   nbload_rd_dc3,
   input  logic                    nbload_inv_dc5,
   input  logic [nbload_tag_w-1:0] nbload_inv_tag_dc5,
   input  logic                    nbload_data_valid,
   input  logic                    nbload_data_error,
   input  logic [nbload_tag_w-1:0] nbload_data_tag,
   input  logic [xlen-1:0]         nbload_data,

   // register file
   input  gpr_wr_t                 i0_wr,
   input  gpr_wr_t                 i1_wr,
   input  gpr_rd_t                 i0_rs1,
   input  gpr_rd_t                 i0_rs2,
   input  gpr_rd_t                 i1_rs1,
   input  gpr_rd_t                 i1_rs2,
   output logic [xlen-1:0]         i0_rs1_data,
   output logic [xlen-1:0]         i0_rs2_data,
   output logic [xlen-1:0]         i1_rs1_data,
   output logic [xlen-1:0]         i1_rs2_data,

   // trace
   input  wb_slot_t                i0_wb,
   input  wb_slot_t                i1_wb,
   input  logic                    int_valid_wb,
   input  logic [num_ecause_w-1:0] exc_cause_wb,
   input  logic [xlen-1:0]         mtval_wb,
   output trace_pkt_t              trace_pkt
);

   gpr_wr_t nbload_wr;                                 // load return write port

   // **************************************************************************
   // stages, all ports connect by matching name
   // **************************************************************************
   dec_nbload_ctl nbload_i (.*);                       // tags -> nbload_wr

   dec_gpr_ctl gpr_i (.*);                             // architectural regs

   dec_trace_ctl trace_i (.*);                         // wb1 trace packet

endmodule

`default_nettype wire

//--- tb_dec.sv
// Testbench for the decode register file slice
// replays dec_trace.txt one row per cycle and checks read data and trace packet
`default_nettype none

module tb_dec
   import dec_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic                    clk = 1'b0;
   logic                    reset;
   logic                    nbload_valid_dc3;
   logic [nbload_tag_w-1:0] nbload_tag_dc3;
   logic [gpr_addr_w-1:0]   nbload_rd_dc3;
   logic                    nbload_inv_dc5;
   logic [nbload_tag_w-1:0] nbload_inv_tag_dc5;
   logic                    nbload_data_valid;
   logic                    nbload_data_error;
   logic [nbload_tag_w-1:0] nbload_data_tag;
   logic [xlen-1:0]         nbload_data;
   gpr_wr_t                 i0_wr;
   gpr_wr_t                 i1_wr;
   gpr_rd_t                 i0_rs1;
   gpr_rd_t                 i0_rs2;
   gpr_rd_t                 i1_rs1;
   gpr_rd_t                 i1_rs2;
   logic [xlen-1:0]         i0_rs1_data;
   logic [xlen-1:0]         i0_rs2_data;
   logic [xlen-1:0]         i1_rs1_data;
   logic [xlen-1:0]         i1_rs2_data;
   wb_slot_t                i0_wb;
   wb_slot_t                i1_wb;
   logic                    int_valid_wb;
   logic [num_ecause_w-1:0] exc_cause_wb;
   logic [xlen-1:0]         mtval_wb;
   trace_pkt_t              trace_pkt;

   logic [31:0] tab [64][40];                          // trace rows of 40 columns
   int          nrows;
   int          errors;
   int          checks;
   int          cycles = 0;
   int          cycle_limit = 1000;                    // replaced once rows are known

   dec dec_i (.*);

   always #10 clk = ~clk;                              // 20 ns period

   // **************************************************************************
   // run limit
   // **************************************************************************
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run passed %0d cycles without finishing", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic string test_name(input logic [31:0] id);
      case (id)
         1:       return "reset";
         2:       return "slot_write";
         3:       return "write_priority";
         4:       return "nbload";
         5:       return "trace";
         default: return "unknown";
      endcase
   endfunction

   // hex tokens fill rows in order and a failed scan marks a comment line
   task automatic read_trace(output bit ok);
      int          fd;
      int          r;
      int          k;
      bit          done;
      logic [31:0] val;
      string       line;
      ok = 1'b0;
      nrows = 0;
      k = 0;
      done = 1'b0;
      fd = $fopen("dec_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open dec_trace.txt for reading");
      end else begin
         while (!done) begin
            r = $fscanf(fd, "%h", val);
            if (r == 1) begin
               if (nrows < 64) begin
                  tab[nrows][k] = val;
               end
               k++;
               if (k == 40) begin                      // row complete
                  k = 0;
                  nrows++;
               end
            end else if (r == 0) begin
               if ($fgets(line, fd) == 0) begin        // skip rest of line
                  done = 1'b1;
               end
            end else begin
               done = 1'b1;                            // end of file
            end
         end
         $fclose(fd);
         if (k != 0) begin
            $display("dec_trace.txt ends in the middle of a row");
         end else if (nrows == 0 || nrows > 64) begin
            $display("dec_trace.txt holds %0d rows, expected 1 to 64", nrows);
         end else begin
            ok = 1'b1;
         end
      end
   endtask

   task automatic drive_idle();
      nbload_valid_dc3   = 1'b0;
      nbload_tag_dc3     = '0;
      nbload_rd_dc3      = '0;
      nbload_inv_dc5     = 1'b0;
      nbload_inv_tag_dc5 = '0;
      nbload_data_valid  = 1'b0;
      nbload_data_error  = 1'b0;
      nbload_data_tag    = '0;
      nbload_data        = '0;
      i0_wr              = '0;
      i1_wr              = '0;
      i0_rs1             = '0;
      i0_rs2             = '0;
      i1_rs1             = '0;
      i1_rs2             = '0;
      i0_wb              = '0;
      i1_wb              = '0;
      int_valid_wb       = 1'b0;
      exc_cause_wb       = '0;
      mtval_wb           = '0;
   endtask

   task automatic drive_row(input int n);
      nbload_valid_dc3   = tab[n][1][0];
      nbload_tag_dc3     = tab[n][2][nbload_tag_w-1:0];
      nbload_rd_dc3      = tab[n][3][gpr_addr_w-1:0];
      nbload_inv_dc5     = tab[n][4][0];
      nbload_inv_tag_dc5 = tab[n][5][nbload_tag_w-1:0];
      nbload_data_valid  = tab[n][6][0];
      nbload_data_error  = tab[n][7][0];
      nbload_data_tag    = tab[n][8][nbload_tag_w-1:0];
      nbload_data        = tab[n][9];
      i0_wr              = {tab[n][10][5:0], tab[n][11]};  // {en, addr} then data
      i1_wr              = {tab[n][12][5:0], tab[n][13]};
      i0_rs1             = tab[n][14][5:0];                // bit 5 is the enable
      i0_rs2             = tab[n][15][5:0];
      i1_rs1             = tab[n][16][5:0];
      i1_rs2             = tab[n][17][5:0];
      i0_wb.valid        = tab[n][18][1];
      i0_wb.exc_valid    = tab[n][18][0];
      i0_wb.instr        = tab[n][19];
      i0_wb.pc           = tab[n][20][31:1];               // file holds byte address
      i1_wb.valid        = tab[n][21][1];
      i1_wb.exc_valid    = tab[n][21][0];
      i1_wb.instr        = tab[n][22];
      i1_wb.pc           = tab[n][23][31:1];
      int_valid_wb       = tab[n][24][0];
      exc_cause_wb       = tab[n][25][num_ecause_w-1:0];
      mtval_wb           = tab[n][26];
   endtask

   task automatic check_field(input string name, input int n, input logic [95:0] exp,
                              input logic [95:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error %s row %0d: expected %h, actual %h", name, n + 1, exp, got);
      end
   endtask

   task automatic check_row(input int n);
      string t;
      t = test_name(tab[n][0]);
      check_field({t, " i0_rs1_data"}, n, tab[n][27], i0_rs1_data);
      check_field({t, " i0_rs2_data"}, n, tab[n][28], i0_rs2_data);
      check_field({t, " i1_rs1_data"}, n, tab[n][29], i1_rs1_data);
      check_field({t, " i1_rs2_data"}, n, tab[n][30], i1_rs2_data);
      check_field({t, " valid"}, n, tab[n][31][2:0], trace_pkt.valid);
      check_field({t, " exception"}, n, tab[n][32][2:0], trace_pkt.exception);
      check_field({t, " interrupt"}, n, tab[n][33][2:0], trace_pkt.interrupt);
      check_field({t, " ecause"}, n, tab[n][34][4:0], trace_pkt.ecause);
      check_field({t, " tval"}, n, tab[n][35], trace_pkt.tval);
      check_field({t, " insn"}, n, {32'b0, tab[n][37], tab[n][36]}, trace_pkt.insn);
      check_field({t, " address"}, n, {32'b0, tab[n][39], tab[n][38]}, trace_pkt.address);
   endtask

   // **************************************************************************
   // main sequence
   // **************************************************************************
   initial begin
      bit ok;
      reset = 1'b1;
      errors = 0;
      checks = 0;
      drive_idle();
      i0_wb.valid     = 1'b1;                          // slots retire while in reset
      i0_wb.exc_valid = 1'b1;
      i1_wb.valid     = 1'b1;
      i1_wb.exc_valid = 1'b1;
      int_valid_wb    = 1'b1;
      read_trace(ok);
      if (!ok) begin
         $display("FAIL: see errors above");
         $finish;
      end else begin
         cycle_limit = nrows + 10 + 20;                // rows, reset, slack
         repeat (10) @(posedge clk);
         @(negedge clk);
         // wb1 strobes held clear by reset
         check_field("reset valid", -1, 96'h0, trace_pkt.valid);
         check_field("reset exception", -1, 96'h0, trace_pkt.exception);
         check_field("reset interrupt", -1, 96'h0, trace_pkt.interrupt);
         drive_idle();
         reset = 1'b0;
         for (int n = 0; n < nrows; n++) begin
            @(negedge clk);                            // drive on falling edge
            drive_row(n);
            #9;                                        // just ahead of rising edge
            check_row(n);
         end
         $display("%0d checks, %0d errors", checks, errors);
         if (errors == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- dec_trace.txt
# tid li lt lr kv kt dv de dt ld  w0 w0d w1 w1d  r0 r1 r2 r3  s0 n0 p0 s1 n1 p1 iv ec tv
# then expected: x0 x1 x2 x3  vl ex in ce tt q0 q1 a0 a1   (hex, w/r = {en,addr}, s = {v,exc})
1 0 0 0 0 0 0 0 0 0  0 0 0 0  21 3f 25 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0  0 0 0 0  21 22 23 24  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0  21 1111 22 2222  21 22 21 22  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0  20 dead 0 0  21 22 21 22  0 0 0 0 0 0 0 0 0  1111 2222 1111 2222  0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0  0 0 23 3333  20 01 22 21  0 0 0 0 0 0 0 0 0  0 0 2222 1111  0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0  0 0 0 0  23 03 23 21  0 0 0 0 0 0 0 0 0  3333 0 3333 1111  0 0 0 0 0 0 0 0 0
3 1 0 05 0 0 0 0 0 0  0 0 0 0  25 00 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 1 0 0 c2c2  25 a0a0 25 b1b1  25 25 25 25  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
3 1 1 06 0 0 0 0 0 0  0 0 0 0  25 25 25 25  0 0 0 0 0 0 0 0 0  b1b1 b1b1 b1b1 b1b1  0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 1 0 1 c2c2  26 a0a0 0 0  26 26 26 26  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0  0 0 0 0  26 26 26 26  0 0 0 0 0 0 0 0 0  a0a0 a0a0 a0a0 a0a0  0 0 0 0 0 0 0 0 0
4 1 2 0a 0 0 0 0 0 0  0 0 0 0  2a 00 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
4 1 3 0b 0 0 0 0 0 0  0 0 0 0  2a 2b 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0  0 0 0 0  2a 2b 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 1 0 2 5a5a  0 0 0 0  2a 2b 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 1 3 0 0 0 0  0 0 0 0  2a 2b 00 00  0 0 0 0 0 0 0 0 0  5a5a 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 1 0 3 7777  0 0 0 0  2a 2b 00 00  0 0 0 0 0 0 0 0 0  5a5a 0 0 0  0 0 0 0 0 0 0 0 0
4 1 0 0c 0 0 0 0 0 0  0 0 0 0  2a 2b 2c 00  0 0 0 0 0 0 0 0 0  5a5a 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 1 1 0 8888  0 0 0 0  2a 2b 2c 00  0 0 0 0 0 0 0 0 0  5a5a 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 1 0 0 9999  0 0 0 0  2a 2b 2c 00  0 0 0 0 0 0 0 0 0  5a5a 0 0 0  0 0 0 0 0 0 0 0 0
4 1 1 0d 0 0 0 0 0 0  0 0 0 0  2a 2b 2c 25  0 0 0 0 0 0 0 0 0  5a5a 0 0 b1b1  0 0 0 0 0 0 0 0 0
4 0 0 0 1 1 1 0 1 4444  0 0 0 0  2d 2c 26 25  0 0 0 0 0 0 0 0 0  0 0 a0a0 b1b1  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0  0 0 0 0  2d 2a 2b 2c  0 0 0 0 0 0 0 0 0  0 5a5a 0 0  0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  2 00500093 1000 2 00a00113 1004 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  1 00000073 2000 0 0 0 0 02 dead  0 0 0 0  3 0 0 0 0 00500093 00a00113 1000 1004
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  0 0 0 3 12345678 abc 0 04 beef  0 0 0 0  1 1 0 02 dead 00000073 0 2000 0
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  0 0 0 0 0 0 1 0b 0  0 0 0 0  2 2 0 04 beef 0 12345678 0 abc
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  4 4 4 0b 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0  0 0 0 0  00 00 00 00  0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 0 0 0

//--- dec.f
dec_pkg.sv
dec_nbload_ctl.sv
dec_gpr_ctl.sv
dec_trace_ctl.sv
dec.sv
tb_dec.sv

//--- Bender.yml
package:
  name: dec

sources:
  - dec_pkg.sv
  - dec_nbload_ctl.sv
  - dec_gpr_ctl.sv
  - dec_trace_ctl.sv
  - dec.sv
  - target: simulation
    files:
      - tb_dec.sv
